/* src/predecode_params.svh */
`default_nettype none

`ifndef PREDECODE_PARAMS_SVH
`define PREDECODE_PARAMS_SVH

// Queue entries, any power of two from 2 up.
`define QUEUE_DEPTH 4

// Instruction word proper.
`define WORD_W 32

// Instruction plus 3 tag bits from memory.
`define INSTR_W 35

// Thumb bit position in the CPSR.
`define CPSR_T 5

// Link bit of a branch instruction.
`define LINK_BIT 24

`endif

`default_nettype wire

/* src/predecode_pkg.sv */
`include "predecode_params.svh"

`default_nettype none

package predecode_pkg;

        // Pointer width follows the queue depth.
        localparam int PTR_W = $clog2(`QUEUE_DEPTH);

        // One queue entry, tag bits on top.
        typedef logic [`INSTR_W-1:0] instr_t;

        // Read or write pointer into the queue.
        typedef logic [PTR_W-1:0] qptr_t;

        // Credit or fill count, 0 up to the depth.
        typedef logic [PTR_W:0] credit_t;

        // Splitter state.
        // ST_PASS passes words through.
        // ST_BRANCH follows an issued link write.
        typedef enum logic
        {
                ST_PASS   = 1'b0,
                ST_BRANCH = 1'b1
        } split_state_t;

endpackage

`default_nettype wire

/* src/instr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface instr_if
        import predecode_pkg::*;
();

        // Driven by the source side.
        instr_t instr;
        logic   valid;
        logic   irq;
        logic   fiq;

        // Driven by the sink side.
        // A word moves on an edge with valid and take both high.
        logic   take;

        modport src
        (
                output instr,
                output valid,
                output irq,
                output fiq,
                input  take
        );

        modport snk
        (
                input  instr,
                input  valid,
                input  irq,
                input  fiq,
                output take
        );

endinterface

`default_nettype wire

/* src/fetch_queue.sv */
`timescale 1ns/1ps
`include "predecode_params.svh"
`default_nettype none

module fetch_queue
        import predecode_pkg::*;
(
        input  wire logic    i_clk,
        input  wire logic    i_reset,
        input  wire logic    i_clear,

        // Fetched words, sent only against credit.
        input  wire instr_t  i_in_instr,
        input  wire logic    i_in_valid,

        // Interrupt levels from the core.
        input  wire logic    i_irq,
        input  wire logic    i_fiq,

        // One pulse per entry consumed.
        output logic         o_credit,

        // Queue head toward the splitter.
        instr_if.src         q2s
);

        // Storage, no reset needed.
        instr_t  mem [`QUEUE_DEPTH];

        qptr_t   wr_ptr;
        qptr_t   rd_ptr;
        credit_t count;

        logic    full;
        logic    push;
        logic    pop;
        logic    irq_ff;
        logic    fiq_ff;

        // Credits keep the sender from overrunning.
        // Full check is a safety net only.
        assign full = (count == credit_t'(`QUEUE_DEPTH));
        assign push = i_in_valid && !full;

        // Head leaves when the splitter takes it.
        assign pop  = q2s.valid && q2s.take;

        // Head is always the oldest entry.
        assign q2s.instr = mem[rd_ptr];
        assign q2s.valid = (count != '0);

        // Interrupts ride with the head.
        assign q2s.irq   = irq_ff;
        assign q2s.fiq   = fiq_ff;

        // Write side.
        always_ff @(posedge i_clk)
        begin
                if (push)
                begin
                        mem[wr_ptr] <= i_in_instr;
                end
        end

        // Pointers and fill count.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        // Clear drops every queued word.
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end
                else
                begin
                        if (push)
                        begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end

                        if (pop)
                        begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end

                        case ({push, pop})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;
                        endcase
                end
        end

        // Credit pulse one cycle after a pop.
        // Clears return nothing; sender refills itself.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        o_credit <= 1'b0;
                end
                else
                begin
                        o_credit <= pop;
                end
        end

        // Registered interrupt levels.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        irq_ff <= 1'b0;
                        fiq_ff <= 1'b0;
                end
                else
                begin
                        irq_ff <= i_irq;
                        fiq_ff <= i_fiq;
                end
        end

endmodule

`default_nettype wire

/* src/bl_split_fsm.sv */
`timescale 1ns/1ps
`include "predecode_params.svh"
`default_nettype none

module bl_split_fsm
        import predecode_pkg::*;
(
        input  wire logic i_clk,
        input  wire logic i_reset,

        // Combined clear and hold, prioritized downstream.
        input  wire logic i_clear,
        input  wire logic i_hold,

        // Thumb bit of the CPSR.
        input  wire logic i_thumb,

        // From the queue head.
        instr_if.snk      q2s,

        // Toward the stage register.
        instr_if.src      s2r
);

        // SUB LR, PC, #4 below the condition field.
        localparam logic [27:0] LINK_ARM   = 28'h24FE004;

        // SUB LR, PC, #1, keeps LR bit 0 set for Thumb return.
        localparam logic [27:0] LINK_THUMB = 28'h24FE001;

        split_state_t state_ff;
        split_state_t state_nxt;

        logic         is_bl;
        logic [27:0]  link_imm;

        // Branch class with the link bit set.
        assign is_bl = q2s.valid
                && (q2s.instr[27:25] == 3'b101)
                && q2s.instr[`LINK_BIT];

        assign link_imm = i_thumb ? LINK_THUMB : LINK_ARM;

        always_comb
        begin
                // Default is a plain pass through.
                s2r.instr = q2s.instr;
                s2r.valid = q2s.valid;
                s2r.irq   = q2s.irq;
                s2r.fiq   = q2s.fiq;
                q2s.take  = s2r.take;
                state_nxt = state_ff;

                case (state_ff)
                ST_PASS:
                begin
                        if (is_bl)
                        begin
                                // Link write first, tag and condition kept.
                                s2r.instr = {q2s.instr[`INSTR_W-1:`WORD_W],
                                             q2s.instr[31:28], link_imm};

                                // BL stays at the head for the second half.
                                q2s.take  = 1'b0;

                                // No interrupt inside the pair.
                                s2r.irq   = 1'b0;
                                s2r.fiq   = 1'b0;

                                if (s2r.take)
                                begin
                                        state_nxt = ST_BRANCH;
                                end
                        end
                end

                ST_BRANCH:
                begin
                        // Same BL again, now a plain branch.
                        s2r.instr            = q2s.instr;
                        s2r.instr[`LINK_BIT] = 1'b0;

                        // Still masked.
                        s2r.irq   = 1'b0;
                        s2r.fiq   = 1'b0;

                        // Pops the head when taken.
                        if (s2r.take)
                        begin
                                state_nxt = ST_PASS;
                        end
                end

                default:
                begin
                        state_nxt = ST_PASS;
                end
                endcase
        end

        // State register.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        state_ff <= ST_PASS;
                end
                else if (!i_hold)
                begin
                        state_ff <= state_nxt;
                end
        end

endmodule

`default_nettype wire

/* src/decode_stage_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_reg
        import predecode_pkg::*;
(
        input  wire logic i_clk,
        input  wire logic i_reset,

        // Listed from highest priority down.
        input  wire logic i_clear_wb,
        input  wire logic i_data_stall,
        input  wire logic i_clear_alu,
        input  wire logic i_stall_shift,
        input  wire logic i_stall_issue,

        // From the splitter.
        instr_if.snk      s2r,

        // Toward the decoder.
        output instr_t    o_instruction,
        output logic      o_instruction_valid,
        output logic      o_irq,
        output logic      o_fiq,

        // Resolved controls for the queue and splitter.
        output logic      o_clear,
        output logic      o_hold
);

        // Writeback clear beats everything.
        // ALU clear only loses to the data stall.
        assign o_clear = i_clear_wb || (!i_data_stall && i_clear_alu);

        // Any stall that no higher clear overrides.
        assign o_hold  = !i_clear_wb
                && (i_data_stall
                    || (!i_clear_alu && (i_stall_shift || i_stall_issue)));

        // Ready only when neither cleared nor held.
        assign s2r.take = !(o_clear || o_hold);

        // Control state.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || o_clear)
                begin
                        o_instruction_valid <= 1'b0;
                        o_irq               <= 1'b0;
                        o_fiq               <= 1'b0;
                end
                else if (s2r.take)
                begin
                        // Interrupts travel with a valid word.
                        o_instruction_valid <= s2r.valid;
                        o_irq               <= s2r.valid && s2r.irq;
                        o_fiq               <= s2r.valid && s2r.fiq;
                end
        end

        // Payload.
        always_ff @(posedge i_clk)
        begin
                if (s2r.take)
                begin
                        o_instruction <= s2r.instr;
                end
        end

endmodule

`default_nettype wire

/* src/predecode_top.sv */
`timescale 1ns/1ps
`include "predecode_params.svh"
`default_nettype none

module predecode_top
        import predecode_pkg::*;
(
        input  wire logic               i_clk,
        input  wire logic               i_reset,

        // Fetch side, credit controlled.
        input  wire instr_t             i_in_instr,
        input  wire logic               i_in_valid,
        output logic                    o_credit,

        // Only the Thumb bit is used.
        input  wire logic [`WORD_W-1:0] i_cpsr,

        // Interrupt levels.
        input  wire logic               i_irq,
        input  wire logic               i_fiq,

        // Clears and stalls, highest priority first.
        input  wire logic               i_clear_from_writeback,
        input  wire logic               i_data_stall,
        input  wire logic               i_clear_from_alu,
        input  wire logic               i_stall_from_shifter,
        input  wire logic               i_stall_from_issue,

        // Toward the decoder.
        output instr_t                  o_instruction,
        output logic                    o_instruction_valid,
        output logic                    o_irq,
        output logic                    o_fiq
);

        // Queue to splitter, splitter to stage register.
        instr_if q2s ();
        instr_if s2r ();

        logic clear;
        logic hold;
        logic thumb;

        assign thumb = i_cpsr[`CPSR_T];

        fetch_queue u_fetch_queue
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_clear        (clear),
                .i_in_instr     (i_in_instr),
                .i_in_valid     (i_in_valid),
                .i_irq          (i_irq),
                .i_fiq          (i_fiq),
                .o_credit       (o_credit),
                .q2s            (q2s.src)
        );

        bl_split_fsm u_bl_split_fsm
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_clear        (clear),
                .i_hold         (hold),
                .i_thumb        (thumb),
                .q2s            (q2s.snk),
                .s2r            (s2r.src)
        );

        // Priority resolved once, here.
        decode_stage_reg u_decode_stage_reg
        (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_clear_wb          (i_clear_from_writeback),
                .i_data_stall        (i_data_stall),
                .i_clear_alu         (i_clear_from_alu),
                .i_stall_shift       (i_stall_from_shifter),
                .i_stall_issue       (i_stall_from_issue),
                .s2r                 (s2r.snk),
                .o_instruction       (o_instruction),
                .o_instruction_valid (o_instruction_valid),
                .o_irq               (o_irq),
                .o_fiq               (o_fiq),
                .o_clear             (clear),
                .o_hold              (hold)
        );

endmodule

`default_nettype wire

/* testbench/tb_predecode.sv */
`timescale 1ns/1ps
`include "predecode_params.svh"
`default_nettype none

module tb_predecode;

        localparam int CREDIT_TIMEOUT = 100;
        localparam int DRAIN_TIMEOUT  = 200;

        logic                i_clk;
        logic                i_reset;
        logic [`INSTR_W-1:0] i_in_instr;
        logic                i_in_valid;
        logic [31:0]         i_cpsr;
        logic                i_irq;
        logic                i_fiq;
        logic                i_clear_from_writeback;
        logic                i_data_stall;
        logic                i_clear_from_alu;
        logic                i_stall_from_shifter;
        logic                i_stall_from_issue;
        logic                o_credit;
        logic [`INSTR_W-1:0] o_instruction;
        logic                o_instruction_valid;
        logic                o_irq;
        logic                o_fiq;

        // Stimulus records from the data file.
        int                  rec_test[$];
        int                  rec_valid[$];
        logic [`INSTR_W-1:0] rec_instr[$];
        int                  rec_thumb[$];
        int                  rec_irq[$];
        int                  rec_fiq[$];
        int                  rec_ctrl[$];

        // Expected stream of raw words as sent.
        logic [`INSTR_W-1:0] model_q[$];
        int                  model_test[$];
        logic                split_phase;

        // Sender side state.
        int                  credits;
        int                  seed;
        int                  cur_test;
        logic                sent_any;

        // Inputs as applied during the current cycle.
        logic                cur_thumb;
        logic                cur_irq;
        logic                cur_fiq;
        logic [3:0]          cur_ctrl;

        // Interrupt levels seen by the queue at the previous edge.
        logic                irq_hist;
        logic                fiq_hist;

        predecode_top i_predecode_top
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_in_instr             (i_in_instr),
                .i_in_valid             (i_in_valid),
                .o_credit               (o_credit),
                .i_cpsr                 (i_cpsr),
                .i_irq                  (i_irq),
                .i_fiq                  (i_fiq),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_stall_from_shifter   (i_stall_from_shifter),
                .i_stall_from_issue     (i_stall_from_issue),
                .o_instruction          (o_instruction),
                .o_instruction_valid    (o_instruction_valid),
                .o_irq                  (o_irq),
                .o_fiq                  (o_fiq)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #10 i_clk = ~i_clk;
        end

        function automatic string test_name(input int id);
                case (id)
                2:       return "pass_through";
                3:       return "bl_arm";
                4:       return "bl_thumb";
                5:       return "stall_credit";
                6:       return "wb_clear";
                default: return "unknown";
                endcase
        endfunction

        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display("Test FAILED");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string name, input string what,
                                       input logic [`INSTR_W-1:0] exp,
                                       input logic [`INSTR_W-1:0] act);
                abort_run($sformatf("FAIL %s: %s expected %h actual %h",
                                    name, what, exp, act));
        endtask

        task automatic read_stimulus();
                int                  fd;
                int                  n;
                int                  t;
                int                  v;
                int                  th;
                int                  iq;
                int                  fq;
                int                  c;
                logic [`INSTR_W-1:0] w;
                logic [8*128-1:0]    line;
                fd = $fopen("testbench/predecode_input.txt", "r");
                if (fd == 0)
                begin
                        abort_run("Could not open testbench/predecode_input.txt.");
                end
                while (!$feof(fd))
                begin
                        line = '0;
                        n = $fgets(line, fd);
                        // Comment and blank lines yield fewer fields.
                        if (n > 0)
                        begin
                                n = $sscanf(line, "%d %h %h %h %h %h %h",
                                            t, v, w, th, iq, fq, c);
                                if (n == 7)
                                begin
                                        rec_test.push_back(t);
                                        rec_valid.push_back(v);
                                        rec_instr.push_back(w);
                                        rec_thumb.push_back(th);
                                        rec_irq.push_back(iq);
                                        rec_fiq.push_back(fq);
                                        rec_ctrl.push_back(c);
                                end
                        end
                end
                $fclose(fd);
        endtask

        // Checks the output against the next word the splitter rule predicts.
        task automatic compare_word();
                logic [`INSTR_W-1:0] head;
                logic [`INSTR_W-1:0] exp_word;
                logic                exp_irq;
                logic                exp_fiq;
                string               name;
                if (model_q.size() == 0)
                begin
                        abort_run("DUT presented a word that was never sent or was lost.");
                end
                else
                begin
                        head    = model_q[0];
                        name    = test_name(model_test[0]);
                        // Pair words never carry interrupts.
                        exp_irq = 1'b0;
                        exp_fiq = 1'b0;
                        if (head[27:25] == 3'b101 && head[`LINK_BIT] && !split_phase)
                        begin
                                // SUB LR, PC, #4 or #1 under the BL condition.
                                exp_word = {head[`INSTR_W-1:28],
                                            cur_thumb ? 28'h24FE001 : 28'h24FE004};
                                split_phase = 1'b1;
                        end
                        else if (head[27:25] == 3'b101 && head[`LINK_BIT])
                        begin
                                exp_word            = head;
                                exp_word[`LINK_BIT] = 1'b0;
                                split_phase         = 1'b0;
                                model_q.pop_front();
                                model_test.pop_front();
                        end
                        else
                        begin
                                exp_word = head;
                                exp_irq  = irq_hist;
                                exp_fiq  = fiq_hist;
                                model_q.pop_front();
                                model_test.pop_front();
                        end
                        assert (o_instruction === exp_word)
                        else report_mismatch(name, "o_instruction", exp_word, o_instruction);
                        assert (o_irq === exp_irq)
                        else report_mismatch(name, "o_irq", exp_irq, o_irq);
                        assert (o_fiq === exp_fiq)
                        else report_mismatch(name, "o_fiq", exp_fiq, o_fiq);
                end
        endtask

        // Runs 1 ns after an edge while the past cycle's inputs still apply.
        task automatic sample_outputs();
                if (!sent_any)
                begin
                        assert (o_instruction_valid === 1'b0)
                        else report_mismatch("reset_idle", "o_instruction_valid", 0,
                                             o_instruction_valid);
                        assert (o_irq === 1'b0 && o_fiq === 1'b0)
                        else report_mismatch("reset_idle", "o_irq/o_fiq", 0, {o_irq, o_fiq});
                        assert (o_credit === 1'b0)
                        else report_mismatch("reset_idle", "o_credit", 0, o_credit);
                end
                if (cur_ctrl[2])
                begin
                        // Clear drops everything and the sender refills.
                        assert (o_instruction_valid === 1'b0)
                        else report_mismatch(test_name(cur_test), "o_instruction_valid", 0,
                                             o_instruction_valid);
                        model_q.delete();
                        model_test.delete();
                        split_phase = 1'b0;
                        credits     = `QUEUE_DEPTH;
                end
                else
                begin
                        if (o_credit === 1'b1)
                        begin
                                credits = credits + 1;
                        end
                        assert (credits <= `QUEUE_DEPTH)
                        else report_mismatch(test_name(cur_test), "credit count",
                                             `QUEUE_DEPTH, credits);
                        // Stage register loaded at this edge only without stall.
                        if (cur_ctrl == 4'h0 && o_instruction_valid === 1'b1)
                        begin
                                compare_word();
                        end
                        else if (cur_ctrl == 4'h0)
                        begin
                                assert (o_irq === 1'b0 && o_fiq === 1'b0)
                                else report_mismatch(test_name(cur_test), "idle o_irq/o_fiq",
                                                     0, {o_irq, o_fiq});
                        end
                end
                irq_hist = cur_irq;
                fiq_hist = cur_fiq;
        endtask

        // One cycle of stimulus driven 2 ns after the edge.
        task automatic drive_cycle(input logic valid, input logic [`INSTR_W-1:0] instr,
                                   input logic thumb, input logic irq, input logic fiq,
                                   input logic [3:0] ctrl);
                i_in_valid             = valid;
                i_in_instr             = instr;
                i_cpsr                 = 32'(thumb) << `CPSR_T;
                i_irq                  = irq;
                i_fiq                  = fiq;
                i_stall_from_issue     = ctrl[0];
                i_data_stall           = ctrl[1];
                i_clear_from_writeback = ctrl[2];
                i_stall_from_shifter   = ctrl[3];
                cur_thumb = thumb;
                cur_irq   = irq;
                cur_fiq   = fiq;
                cur_ctrl  = ctrl;
                if (valid)
                begin
                        credits  = credits - 1;
                        sent_any = 1'b1;
                        model_q.push_back(instr);
                        model_test.push_back(cur_test);
                end
                @(posedge i_clk);
                #1;
                sample_outputs();
                #1;
        endtask

        task automatic idle_cycle();
                drive_cycle(1'b0, '0, cur_thumb, cur_irq, cur_fiq, 4'h0);
        endtask

        task automatic wait_for_credit();
                int n;
                n = 0;
                while (credits == 0 && n < CREDIT_TIMEOUT)
                begin
                        idle_cycle();
                        n = n + 1;
                end
                if (credits == 0)
                begin
                        abort_run("Timeout waiting for a credit to come back.");
                end
        endtask

        task automatic drain_pipeline();
                int n;
                n = 0;
                while (model_q.size() != 0 && n < DRAIN_TIMEOUT)
                begin
                        idle_cycle();
                        n = n + 1;
                end
                if (model_q.size() != 0)
                begin
                        abort_run("Timeout waiting for the expected words to drain.");
                end
        endtask

        initial
        begin
                int jitter;
                seed                   = 32'hb159;
                i_reset                = 1'b1;
                i_in_instr             = '0;
                i_in_valid             = 1'b0;
                i_cpsr                 = '0;
                i_irq                  = 1'b0;
                i_fiq                  = 1'b0;
                i_clear_from_writeback = 1'b0;
                i_data_stall           = 1'b0;
                i_clear_from_alu       = 1'b0;
                i_stall_from_shifter   = 1'b0;
                i_stall_from_issue     = 1'b0;
                credits     = `QUEUE_DEPTH;
                split_phase = 1'b0;
                sent_any    = 1'b0;
                cur_test    = 0;
                cur_thumb   = 1'b0;
                cur_irq     = 1'b0;
                cur_fiq     = 1'b0;
                cur_ctrl    = 4'h0;
                irq_hist    = 1'b0;
                fiq_hist    = 1'b0;
                read_stimulus();
                if (rec_test.size() == 0)
                begin
                        abort_run("No stimulus records found in the input file.");
                end
                repeat (16) @(posedge i_clk);
                #2;
                i_reset = 1'b0;
                // Quiet outputs before the first send.
                repeat (3) idle_cycle();
                for (int i = 0; i < rec_test.size(); i++)
                begin
                        cur_test = rec_test[i];
                        if (rec_valid[i] != 0)
                        begin
                                // Random gap before each send.
                                jitter = $unsigned($random(seed)) % 3;
                                repeat (jitter) idle_cycle();
                                wait_for_credit();
                        end
                        drive_cycle(rec_valid[i] != 0, rec_instr[i], rec_thumb[i] != 0,
                                    rec_irq[i] != 0, rec_fiq[i] != 0, 4'(rec_ctrl[i]));
                end
                drain_pipeline();
                // Anything extra now is a duplicate.
                repeat (4) idle_cycle();
                assert (credits == `QUEUE_DEPTH)
                else report_mismatch("final_credit", "credit count", `QUEUE_DEPTH, credits);
                $display("Test OK");
                $finish;
        end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/predecode_pkg.sv
src/instr_if.sv
src/fetch_queue.sv
src/bl_split_fsm.sv
src/decode_stage_reg.sv
src/predecode_top.sv
testbench/tb_predecode.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_predecode
FILELIST  := all.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal

BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard src/*.svh)
DATA      := testbench/predecode_input.txt

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes.
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the simulator is the test result.
run: $(BIN) $(DATA)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/predecode_input.txt */
# test valid instr thumb irq fiq ctrl (instr is 35-bit hex, top digit holds the 3 tag bits)
# ctrl bits: 0 issue stall, 1 data stall, 2 writeback clear, 3 shifter stall
2 1 0E3A01005 0 0 0 0
2 1 1E0811002 0 1 0 0
2 1 2E5912004 0 1 1 0
2 1 0EA000010 0 0 1 0
2 1 7E1A00000 0 0 0 0
3 1 0EB000010 0 0 0 0
3 1 50B000004 0 1 0 0
3 1 0E2800001 0 1 1 0
3 1 0AB0FFFFE 0 0 0 0
4 1 0EB000020 1 0 0 0
4 1 61B00ABCD 1 0 1 0
4 1 0E1A0F00E 1 0 0 0
5 1 0E3A02007 0 0 0 1
5 0 000000000 0 0 0 1
5 0 000000000 0 0 0 1
5 1 0EB000100 0 0 0 2
5 0 000000000 0 0 0 2
5 1 0E3A03009 0 1 0 1
5 1 0E0844005 0 0 0 8
5 0 000000000 0 1 0 2
5 1 0EB000200 0 0 0 0
5 1 0E3A0400A 0 0 0 1
6 1 0E3A05001 0 0 0 2
6 1 0EB000300 0 0 0 2
6 1 0E3A05002 0 0 0 2
6 0 000000000 0 0 0 4
6 1 0E3A06001 0 0 0 0
6 1 0EB000400 1 0 0 0
6 1 0E3A06002 0 0 0 0
6 1 0E3A06003 0 1 0 0
